/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

typedef logic [7:0] data_t;
typedef logic [15:0] addr_t;

typedef enum logic [5:0] {
	OP_NOP,
	OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
	OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR, OP_CMP,
	OP_ASL, OP_LSR, OP_ROL, OP_ROR,
	OP_INX, OP_INY, OP_DEX, OP_DEY,
	OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS,
	OP_SEC, OP_CLC, OP_SEI, OP_CLI, OP_CLV,
	OP_PHA, OP_PLA, OP_PHP, OP_PLP, OP_JMP
} op_t;

typedef enum logic [1:0] {MODE_IMP, MODE_IMM, MODE_ZP, MODE_ABS} mode_t;

typedef enum logic [3:0] {
	ALU_TXA, ALU_TXB, ALU_ADD, ALU_SUB, ALU_AND, ALU_ORA, ALU_EOR, ALU_ROL, ALU_ROR
} alu_func_t;

typedef enum logic [2:0] {ASRC_A, ASRC_X, ASRC_Y, ASRC_SP, ASRC_P} a_src_t;
typedef enum logic {BSRC_MEM, BSRC_ONE} b_src_t;
typedef enum logic [1:0] {ADDR_PC, ADDR_LATCH, ADDR_STACK} addr_sel_t;

typedef struct packed {
	logic a;
	logic x;
	logic y;
	logic sp;
	logic p;
	logic dll;
	logic dlh;
} dst_t;

typedef struct packed {
	addr_sel_t addr_sel;
	logic pc_inc;
	logic pc_load;
	logic ir_we;
	logic dlh_clr;
	logic mem_we;
	a_src_t a_src;
	b_src_t b_src;
	alu_func_t alu_func;
	// Carry-in becomes the no-borrow value of the selected function
	logic cin_force;
	dst_t dst;
	data_t p_mask;
	data_t p_set;
	data_t p_clr;
} ctrl_t;

localparam int STATUS_C = 0;
localparam int STATUS_Z = 1;
localparam int STATUS_I = 2;
localparam int STATUS_D = 3;
localparam int STATUS_V = 6;
localparam int STATUS_N = 7;

endpackage

`default_nettype wire

/* cpu_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_decoder (
	input  cpu_pkg::data_t ir_i,
	output cpu_pkg::op_t   op_o,
	output cpu_pkg::mode_t mode_o
);

always_comb begin
	case (ir_i)
	8'hA9, 8'hA5, 8'hAD: op_o = cpu_pkg::OP_LDA;
	8'hA2, 8'hA6, 8'hAE: op_o = cpu_pkg::OP_LDX;
	8'hA0, 8'hA4, 8'hAC: op_o = cpu_pkg::OP_LDY;
	8'h69, 8'h65, 8'h6D: op_o = cpu_pkg::OP_ADC;
	8'hE9, 8'hE5, 8'hED: op_o = cpu_pkg::OP_SBC;
	8'h29, 8'h25, 8'h2D: op_o = cpu_pkg::OP_AND;
	8'h09, 8'h05, 8'h0D: op_o = cpu_pkg::OP_ORA;
	8'h49, 8'h45, 8'h4D: op_o = cpu_pkg::OP_EOR;
	8'hC9, 8'hC5, 8'hCD: op_o = cpu_pkg::OP_CMP;
	8'h85, 8'h8D: op_o = cpu_pkg::OP_STA;
	8'h86, 8'h8E: op_o = cpu_pkg::OP_STX;
	8'h84, 8'h8C: op_o = cpu_pkg::OP_STY;
	8'h0A: op_o = cpu_pkg::OP_ASL;
	8'h4A: op_o = cpu_pkg::OP_LSR;
	8'h2A: op_o = cpu_pkg::OP_ROL;
	8'h6A: op_o = cpu_pkg::OP_ROR;
	8'hE8: op_o = cpu_pkg::OP_INX;
	8'hC8: op_o = cpu_pkg::OP_INY;
	8'hCA: op_o = cpu_pkg::OP_DEX;
	8'h88: op_o = cpu_pkg::OP_DEY;
	8'hAA: op_o = cpu_pkg::OP_TAX;
	8'hA8: op_o = cpu_pkg::OP_TAY;
	8'h8A: op_o = cpu_pkg::OP_TXA;
	8'h98: op_o = cpu_pkg::OP_TYA;
	8'hBA: op_o = cpu_pkg::OP_TSX;
	8'h9A: op_o = cpu_pkg::OP_TXS;
	8'h38: op_o = cpu_pkg::OP_SEC;
	8'h18: op_o = cpu_pkg::OP_CLC;
	8'h78: op_o = cpu_pkg::OP_SEI;
	8'h58: op_o = cpu_pkg::OP_CLI;
	8'hB8: op_o = cpu_pkg::OP_CLV;
	8'h48: op_o = cpu_pkg::OP_PHA;
	8'h68: op_o = cpu_pkg::OP_PLA;
	8'h08: op_o = cpu_pkg::OP_PHP;
	8'h28: op_o = cpu_pkg::OP_PLP;
	8'h4C: op_o = cpu_pkg::OP_JMP;
	default: op_o = cpu_pkg::OP_NOP;
	endcase
end

// Mode from the bbb and cc fields of the opcode
always_comb begin
	case (ir_i[4:2])
	3'b001: mode_o = cpu_pkg::MODE_ZP;
	3'b011: mode_o = cpu_pkg::MODE_ABS;
	3'b010: mode_o = (ir_i[1:0] == 2'b01) ? cpu_pkg::MODE_IMM : cpu_pkg::MODE_IMP;
	3'b000: mode_o = (ir_i[1:0] == 2'b01) ? cpu_pkg::MODE_IMP : cpu_pkg::MODE_IMM;
	default: mode_o = cpu_pkg::MODE_IMP;
	endcase
	if (op_o == cpu_pkg::OP_NOP)
		mode_o = cpu_pkg::MODE_IMP;
end

endmodule

`default_nettype wire

/* cpu_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer (
	input  logic           sys,
	input  logic           rst_i,
	input  cpu_pkg::op_t   op_i,
	input  cpu_pkg::mode_t mode_i,
	output cpu_pkg::ctrl_t ctrl_o,
	output logic           sync_o
);

typedef enum logic [2:0] {
	VECTOR_LO, VECTOR_HI, FETCH, DECODE, READ_HI, OPERAND, PUSH, PULL
} state_t;

state_t state, state_next;
logic execute;

always_ff @(posedge sys) begin
	if (rst_i)
		state <= VECTOR_LO;
	else
		state <= state_next;
end

assign sync_o = (state == FETCH);

always_comb begin
	ctrl_o = '0;
	ctrl_o.addr_sel = cpu_pkg::ADDR_PC;
	ctrl_o.a_src = cpu_pkg::ASRC_A;
	ctrl_o.b_src = cpu_pkg::BSRC_MEM;
	ctrl_o.alu_func = cpu_pkg::ALU_TXB;
	state_next = state;
	execute = 1'b0;

	case (state)
	VECTOR_LO: begin
		ctrl_o.pc_inc = 1'b1;
		ctrl_o.dst.dll = 1'b1;
		state_next = VECTOR_HI;
	end
	VECTOR_HI: begin
		ctrl_o.pc_load = 1'b1;
		state_next = FETCH;
	end
	FETCH: begin
		ctrl_o.pc_inc = 1'b1;
		ctrl_o.ir_we = 1'b1;
		state_next = DECODE;
	end
	DECODE: begin
		case (mode_i)
		cpu_pkg::MODE_IMP: begin
			if (op_i == cpu_pkg::OP_PLA || op_i == cpu_pkg::OP_PLP) begin
				// SP up by one before the stack read
				ctrl_o.a_src = cpu_pkg::ASRC_SP;
				ctrl_o.b_src = cpu_pkg::BSRC_ONE;
				ctrl_o.alu_func = cpu_pkg::ALU_ADD;
				ctrl_o.cin_force = 1'b1;
				ctrl_o.dst.sp = 1'b1;
				state_next = PULL;
			end else begin
				execute = 1'b1;
				if (op_i == cpu_pkg::OP_PHA || op_i == cpu_pkg::OP_PHP)
					state_next = PUSH;
				else
					state_next = FETCH;
			end
		end
		cpu_pkg::MODE_IMM: begin
			ctrl_o.pc_inc = 1'b1;
			execute = 1'b1;
			state_next = FETCH;
		end
		default: begin
			ctrl_o.pc_inc = 1'b1;
			ctrl_o.dst.dll = 1'b1;
			ctrl_o.dlh_clr = (mode_i == cpu_pkg::MODE_ZP);
			state_next = (mode_i == cpu_pkg::MODE_ZP) ? OPERAND : READ_HI;
		end
		endcase
	end
	READ_HI: begin
		if (op_i == cpu_pkg::OP_JMP) begin
			ctrl_o.pc_load = 1'b1;
			state_next = FETCH;
		end else begin
			ctrl_o.pc_inc = 1'b1;
			ctrl_o.dst.dlh = 1'b1;
			state_next = OPERAND;
		end
	end
	OPERAND: begin
		// Implied mode only gets here as the idle cycle after a pull
		if (mode_i != cpu_pkg::MODE_IMP) begin
			ctrl_o.addr_sel = cpu_pkg::ADDR_LATCH;
			execute = 1'b1;
		end
		state_next = FETCH;
	end
	PUSH: begin
		ctrl_o.a_src = cpu_pkg::ASRC_SP;
		ctrl_o.b_src = cpu_pkg::BSRC_ONE;
		ctrl_o.alu_func = cpu_pkg::ALU_SUB;
		ctrl_o.cin_force = 1'b1;
		ctrl_o.dst.sp = 1'b1;
		state_next = FETCH;
	end
	PULL: begin
		ctrl_o.addr_sel = cpu_pkg::ADDR_STACK;
		execute = 1'b1;
		state_next = OPERAND;
	end
	default: state_next = FETCH;
	endcase

	if (execute) begin
		case (op_i)
		cpu_pkg::OP_STA, cpu_pkg::OP_STX, cpu_pkg::OP_STY, cpu_pkg::OP_TAX,
		cpu_pkg::OP_TAY, cpu_pkg::OP_TXA, cpu_pkg::OP_TYA, cpu_pkg::OP_TSX,
		cpu_pkg::OP_TXS, cpu_pkg::OP_PHA, cpu_pkg::OP_PHP:
			ctrl_o.alu_func = cpu_pkg::ALU_TXA;
		cpu_pkg::OP_ADC, cpu_pkg::OP_INX, cpu_pkg::OP_INY:
			ctrl_o.alu_func = cpu_pkg::ALU_ADD;
		cpu_pkg::OP_SBC, cpu_pkg::OP_CMP, cpu_pkg::OP_DEX, cpu_pkg::OP_DEY:
			ctrl_o.alu_func = cpu_pkg::ALU_SUB;
		cpu_pkg::OP_AND: ctrl_o.alu_func = cpu_pkg::ALU_AND;
		cpu_pkg::OP_ORA: ctrl_o.alu_func = cpu_pkg::ALU_ORA;
		cpu_pkg::OP_EOR: ctrl_o.alu_func = cpu_pkg::ALU_EOR;
		cpu_pkg::OP_ASL, cpu_pkg::OP_ROL: ctrl_o.alu_func = cpu_pkg::ALU_ROL;
		cpu_pkg::OP_LSR, cpu_pkg::OP_ROR: ctrl_o.alu_func = cpu_pkg::ALU_ROR;
		default: ;
		endcase

		case (op_i)
		cpu_pkg::OP_STX, cpu_pkg::OP_TXA, cpu_pkg::OP_TXS, cpu_pkg::OP_INX,
		cpu_pkg::OP_DEX: ctrl_o.a_src = cpu_pkg::ASRC_X;
		cpu_pkg::OP_STY, cpu_pkg::OP_TYA, cpu_pkg::OP_INY,
		cpu_pkg::OP_DEY: ctrl_o.a_src = cpu_pkg::ASRC_Y;
		cpu_pkg::OP_TSX: ctrl_o.a_src = cpu_pkg::ASRC_SP;
		cpu_pkg::OP_PHP: ctrl_o.a_src = cpu_pkg::ASRC_P;
		default: ;
		endcase

		case (op_i)
		cpu_pkg::OP_LDA, cpu_pkg::OP_ADC, cpu_pkg::OP_SBC, cpu_pkg::OP_AND,
		cpu_pkg::OP_ORA, cpu_pkg::OP_EOR, cpu_pkg::OP_ASL, cpu_pkg::OP_LSR,
		cpu_pkg::OP_ROL, cpu_pkg::OP_ROR, cpu_pkg::OP_TXA, cpu_pkg::OP_TYA,
		cpu_pkg::OP_PLA: ctrl_o.dst.a = 1'b1;
		cpu_pkg::OP_LDX, cpu_pkg::OP_TAX, cpu_pkg::OP_TSX, cpu_pkg::OP_INX,
		cpu_pkg::OP_DEX: ctrl_o.dst.x = 1'b1;
		cpu_pkg::OP_LDY, cpu_pkg::OP_TAY, cpu_pkg::OP_INY,
		cpu_pkg::OP_DEY: ctrl_o.dst.y = 1'b1;
		cpu_pkg::OP_TXS: ctrl_o.dst.sp = 1'b1;
		cpu_pkg::OP_PLP: ctrl_o.dst.p = 1'b1;
		cpu_pkg::OP_STA, cpu_pkg::OP_STX, cpu_pkg::OP_STY: ctrl_o.mem_we = 1'b1;
		cpu_pkg::OP_PHA, cpu_pkg::OP_PHP: begin
			ctrl_o.addr_sel = cpu_pkg::ADDR_STACK;
			ctrl_o.mem_we = 1'b1;
		end
		default: ;
		endcase

		// Shifts take in zero, inc/dec add or subtract one
		case (op_i)
		cpu_pkg::OP_INX, cpu_pkg::OP_INY, cpu_pkg::OP_DEX, cpu_pkg::OP_DEY: begin
			ctrl_o.b_src = cpu_pkg::BSRC_ONE;
			ctrl_o.cin_force = 1'b1;
		end
		cpu_pkg::OP_CMP, cpu_pkg::OP_ASL, cpu_pkg::OP_LSR: ctrl_o.cin_force = 1'b1;
		default: ;
		endcase

		ctrl_o.p_mask[cpu_pkg::STATUS_N] = ctrl_o.dst.a | ctrl_o.dst.x | ctrl_o.dst.y |
			(op_i == cpu_pkg::OP_CMP);
		ctrl_o.p_mask[cpu_pkg::STATUS_Z] = ctrl_o.p_mask[cpu_pkg::STATUS_N];
		case (op_i)
		cpu_pkg::OP_ADC, cpu_pkg::OP_SBC: begin
			ctrl_o.p_mask[cpu_pkg::STATUS_C] = 1'b1;
			ctrl_o.p_mask[cpu_pkg::STATUS_V] = 1'b1;
		end
		cpu_pkg::OP_CMP, cpu_pkg::OP_ASL, cpu_pkg::OP_LSR, cpu_pkg::OP_ROL,
		cpu_pkg::OP_ROR: ctrl_o.p_mask[cpu_pkg::STATUS_C] = 1'b1;
		cpu_pkg::OP_SEC: ctrl_o.p_set[cpu_pkg::STATUS_C] = 1'b1;
		cpu_pkg::OP_SEI: ctrl_o.p_set[cpu_pkg::STATUS_I] = 1'b1;
		cpu_pkg::OP_CLC: ctrl_o.p_clr[cpu_pkg::STATUS_C] = 1'b1;
		cpu_pkg::OP_CLI: ctrl_o.p_clr[cpu_pkg::STATUS_I] = 1'b1;
		cpu_pkg::OP_CLV: ctrl_o.p_clr[cpu_pkg::STATUS_V] = 1'b1;
		default: ;
		endcase
	end
end

endmodule

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
	input  cpu_pkg::alu_func_t func_i,
	input  cpu_pkg::data_t     a_i,
	input  cpu_pkg::data_t     b_i,
	input  logic               cin_i,
	output cpu_pkg::data_t     y_o,
	output logic               n_o,
	output logic               z_o,
	output logic               c_o,
	output logic               v_o
);

cpu_pkg::data_t b_eff;
logic [8:0] sum;

// Subtract is add of the inverted operand
assign b_eff = (func_i == cpu_pkg::ALU_SUB) ? ~b_i : b_i;
assign sum = {1'b0, a_i} + {1'b0, b_eff} + {8'd0, cin_i};

always_comb begin
	y_o = a_i;
	c_o = cin_i;
	v_o = 1'b0;
	case (func_i)
	cpu_pkg::ALU_TXA: y_o = a_i;
	cpu_pkg::ALU_TXB: y_o = b_i;
	cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
		y_o = sum[7:0];
		c_o = sum[8];
		// Signed overflow
		v_o = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);
	end
	cpu_pkg::ALU_AND: y_o = a_i & b_i;
	cpu_pkg::ALU_ORA: y_o = a_i | b_i;
	cpu_pkg::ALU_EOR: y_o = a_i ^ b_i;
	cpu_pkg::ALU_ROL: begin
		y_o = {a_i[6:0], cin_i};
		c_o = a_i[7];
	end
	cpu_pkg::ALU_ROR: begin
		y_o = {cin_i, a_i[7:1]};
		c_o = a_i[0];
	end
	default: ;
	endcase
end

assign n_o = y_o[7];
assign z_o = (y_o == 8'd0);

endmodule

`default_nettype wire

/* cpu_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath #(
	parameter cpu_pkg::addr_t RESET_VECTOR = 16'hFFFC
) (
	input  logic           sys,
	input  logic           rst_i,
	input  cpu_pkg::ctrl_t ctrl_i,
	input  cpu_pkg::data_t data_i,
	output cpu_pkg::data_t ir_o,
	output cpu_pkg::addr_t addr_o,
	output cpu_pkg::data_t data_o,
	output logic           we_o
);

cpu_pkg::data_t a_q, x_q, y_q, sp_q, p_q, ir_q, dll_q, dlh_q;
cpu_pkg::addr_t pc_q;
cpu_pkg::data_t p_rd, alu_a, alu_b, alu_y, flags, p_next;
logic cin, alu_n, alu_z, alu_c, alu_v;

// Bit 5 always reads as one
assign p_rd = p_q | 8'h20;

always_comb begin
	case (ctrl_i.a_src)
	cpu_pkg::ASRC_X: alu_a = x_q;
	cpu_pkg::ASRC_Y: alu_a = y_q;
	cpu_pkg::ASRC_SP: alu_a = sp_q;
	cpu_pkg::ASRC_P: alu_a = p_rd;
	default: alu_a = a_q;
	endcase
end

assign alu_b = (ctrl_i.b_src == cpu_pkg::BSRC_ONE) ? 8'd1 : data_i;
assign cin = ctrl_i.cin_force ? (ctrl_i.alu_func == cpu_pkg::ALU_SUB) : p_q[cpu_pkg::STATUS_C];

cpu_alu u_cpu_alu (
	.func_i (ctrl_i.alu_func),
	.a_i    (alu_a),
	.b_i    (alu_b),
	.cin_i  (cin),
	.y_o    (alu_y),
	.n_o    (alu_n),
	.z_o    (alu_z),
	.c_o    (alu_c),
	.v_o    (alu_v)
);

always_comb begin
	flags = 8'd0;
	flags[cpu_pkg::STATUS_N] = alu_n;
	flags[cpu_pkg::STATUS_Z] = alu_z;
	flags[cpu_pkg::STATUS_C] = alu_c;
	flags[cpu_pkg::STATUS_V] = alu_v;
	p_next = ctrl_i.dst.p ? alu_y : p_q;
	p_next = (p_next & ~ctrl_i.p_mask) | (flags & ctrl_i.p_mask);
	p_next = (p_next | ctrl_i.p_set) & ~ctrl_i.p_clr;
end

always_ff @(posedge sys) begin
	if (rst_i) begin
		a_q <= 8'h00;
		x_q <= 8'h00;
		y_q <= 8'h00;
		sp_q <= 8'hFF;
		p_q <= 8'h24;
		pc_q <= RESET_VECTOR;
	end else begin
		if (ctrl_i.dst.a)
			a_q <= alu_y;
		if (ctrl_i.dst.x)
			x_q <= alu_y;
		if (ctrl_i.dst.y)
			y_q <= alu_y;
		if (ctrl_i.dst.sp)
			sp_q <= alu_y;
		p_q <= p_next;
		// Jump target is the byte on the ALU with the latched low byte
		if (ctrl_i.pc_load)
			pc_q <= {alu_y, dll_q};
		else if (ctrl_i.pc_inc)
			pc_q <= pc_q + 16'd1;
	end
end

always_ff @(posedge sys) begin
	if (ctrl_i.ir_we)
		ir_q <= data_i;
	if (ctrl_i.dst.dll)
		dll_q <= alu_y;
	if (ctrl_i.dlh_clr)
		dlh_q <= 8'h00;
	else if (ctrl_i.dst.dlh)
		dlh_q <= alu_y;
end

always_comb begin
	case (ctrl_i.addr_sel)
	cpu_pkg::ADDR_LATCH: addr_o = {dlh_q, dll_q};
	cpu_pkg::ADDR_STACK: addr_o = {8'h01, sp_q};
	default: addr_o = pc_q;
	endcase
end

assign ir_o = ir_q;
assign data_o = alu_y;
assign we_o = ctrl_i.mem_we;

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::addr_t RESET_VECTOR = 16'hFFFC
) (
	input  logic           sys,
	input  logic           rst_i,
	output cpu_pkg::addr_t addr_o,
	output cpu_pkg::data_t data_o,
	input  cpu_pkg::data_t data_i,
	output logic           we_o,
	output logic           sync_o
);

cpu_pkg::data_t ir;
cpu_pkg::op_t op;
cpu_pkg::mode_t mode;
cpu_pkg::ctrl_t ctrl;

cpu_decoder u_cpu_decoder (
	.ir_i   (ir),
	.op_o   (op),
	.mode_o (mode)
);

cpu_sequencer u_cpu_sequencer (
	.sys    (sys),
	.rst_i  (rst_i),
	.op_i   (op),
	.mode_i (mode),
	.ctrl_o (ctrl),
	.sync_o (sync_o)
);

cpu_datapath #(
	.RESET_VECTOR (RESET_VECTOR)
) u_cpu_datapath (
	.sys    (sys),
	.rst_i  (rst_i),
	.ctrl_i (ctrl),
	.data_i (data_i),
	.ir_o   (ir),
	.addr_o (addr_o),
	.data_o (data_o),
	.we_o   (we_o)
);

endmodule

`default_nettype wire

/* cpu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
	input logic                sys,
	input logic                rst_i,
	input logic                we_i,
	input logic                sync_i,
	input cpu_pkg::addr_t      addr_i,
	input cpu_pkg::addr_sel_t  addr_sel_i
);

no_write_in_fetch: assert property (@(posedge sys) !(we_i && sync_i))
	else $error("write strobe high in an opcode fetch cycle");

quiet_in_reset: assert property (@(posedge sys) $past(rst_i) |-> !we_i && !sync_i)
	else $error("memory port active during reset");

// Stores go to the stack page or to the latched operand address
write_target: assert property (@(posedge sys) disable iff (rst_i)
	we_i |-> (addr_sel_i == cpu_pkg::ADDR_LATCH) ||
		(addr_sel_i == cpu_pkg::ADDR_STACK && addr_i[15:8] == 8'h01))
	else $error("write to an address not taken from the program or the stack");

endmodule

bind cpu_top cpu_checker u_cpu_checker (
	.sys        (sys),
	.rst_i      (rst_i),
	.we_i       (we_o),
	.sync_i     (sync_o),
	.addr_i     (addr_o),
	.addr_sel_i (ctrl.addr_sel)
);

`default_nettype wire

/* tb_cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top;

logic sys = 1'b0;
logic rst_i = 1'b1;
cpu_pkg::addr_t addr_o;
cpu_pkg::data_t data_o;
cpu_pkg::data_t data_i;
logic we_o;
logic sync_o;

cpu_pkg::data_t mem [0:65535];
logic [31:0] lfsr = 32'h3920_1ea0;
int cyc_n;
int elapsed;
int budget;
int errors;
cpu_pkg::addr_t sync_a[$];
int sync_t[$];
cpu_pkg::addr_t wr_a[$];
cpu_pkg::data_t wr_d[$];
cpu_pkg::addr_t ins_addr[$];
int ins_cyc[$];
cpu_pkg::addr_t exp_wa[$];
cpu_pkg::data_t exp_wd[$];
cpu_pkg::addr_t pc_w;
cpu_pkg::addr_t vec;
// Reference register model
cpu_pkg::data_t m_a, m_p, m_sp;

cpu_top #(
	.RESET_VECTOR (16'hFFFC)
) u_cpu_top (
	.sys    (sys),
	.rst_i  (rst_i),
	.addr_o (addr_o),
	.data_o (data_o),
	.data_i (data_i),
	.we_o   (we_o),
	.sync_o (sync_o)
);

always #10 sys = ~sys;

assign data_i = mem[addr_o];

always @(posedge sys) begin
	if (we_o)
		mem[addr_o] <= data_o;
end

// Port activity sampled away from the rising edge
always @(negedge sys) begin
	if (!rst_i) begin
		cyc_n = cyc_n + 1;
		if (sync_o) begin
			sync_a.push_back(addr_o);
			sync_t.push_back(cyc_n);
		end
		if (we_o) begin
			wr_a.push_back(addr_o);
			wr_d.push_back(data_o);
		end
	end
end

always @(posedge sys) begin
	elapsed = elapsed + 1;
	if (elapsed > 2 * budget) begin
		$display("timeout: program did not reach its final loop after %0d cycles", elapsed);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end
end

function automatic cpu_pkg::data_t next_byte();
	cpu_pkg::data_t b;
	logic fb;
	b = 8'h00;
	for (int i = 0; i < 8; i++) begin
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		b = {b[6:0], fb};
	end
	return b;
endfunction

function automatic cpu_pkg::data_t nz(cpu_pkg::data_t p, cpu_pkg::data_t v);
	cpu_pkg::data_t r;
	r = p;
	r[7] = v[7];
	r[1] = (v == 8'h00);
	return r;
endfunction

task automatic stop_run(string msg);
	$display("%s", msg);
	$display("=== FAIL ===");
	errors = errors + 1;
	$fatal(1, "stopped at first error");
endtask

task automatic check_data(string name, cpu_pkg::data_t got, cpu_pkg::data_t exp);
	if (got !== exp)
		stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_addr(string name, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
	if (got !== exp)
		stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_count(string name, int got, int exp);
	if (got != exp)
		stop_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
endtask

// Hold the core in reset and lay out a fresh memory image
task automatic start_prog();
	cpu_pkg::data_t hi, lo;
	budget = budget + 10;
	@(posedge sys);
	rst_i <= 1'b1;
	repeat (8) @(posedge sys);
	for (int i = 0; i < 65536; i++)
		mem[i] = cpu_pkg::data_t'(i ^ (i >> 8) ^ 8'h5A);
	hi = next_byte();
	lo = next_byte();
	vec = {2'b10, hi[5:0], lo};
	mem[16'hFFFC] = vec[7:0];
	mem[16'hFFFD] = vec[15:8];
	pc_w = vec;
	ins_addr.delete();
	ins_cyc.delete();
	exp_wa.delete();
	exp_wd.delete();
	sync_a.delete();
	sync_t.delete();
	wr_a.delete();
	wr_d.delete();
	cyc_n = 0;
	m_a = 8'h00;
	m_p = 8'h24;
	m_sp = 8'hFF;
endtask

task automatic put(cpu_pkg::data_t b);
	mem[pc_w] = b;
	pc_w = pc_w + 16'd1;
endtask

task automatic ins(cpu_pkg::data_t opc, int cyc);
	ins_addr.push_back(pc_w);
	ins_cyc.push_back(cyc);
	put(opc);
endtask

task automatic imm(cpu_pkg::data_t opc, cpu_pkg::data_t v);
	ins(opc, 2);
	put(v);
endtask

task automatic zp(cpu_pkg::data_t opc, cpu_pkg::data_t a);
	ins(opc, 3);
	put(a);
endtask

task automatic abs(cpu_pkg::data_t opc, cpu_pkg::addr_t a, int cyc);
	ins(opc, cyc);
	put(a[7:0]);
	put(a[15:8]);
endtask

task automatic expect_wr(cpu_pkg::addr_t a, cpu_pkg::data_t d);
	exp_wa.push_back(a);
	exp_wd.push_back(d);
endtask

task automatic push_p();
	ins(8'h08, 3);
	expect_wr({8'h01, m_sp}, m_p | 8'h20);
	m_sp = m_sp - 8'd1;
endtask

// Accumulator operations as the instruction set defines them
task automatic model_op(cpu_pkg::data_t opc, cpu_pkg::data_t b);
	logic [8:0] s;
	cpu_pkg::data_t bb;
	bb = (opc == 8'hE9) ? ~b : b;
	case (opc)
	8'h69, 8'hE9: begin
		s = {1'b0, m_a} + {1'b0, bb} + {8'd0, m_p[0]};
		m_p[6] = (m_a[7] == bb[7]) && (s[7] != m_a[7]);
		m_p[0] = s[8];
		m_a = s[7:0];
	end
	8'hC9: begin
		s = {1'b0, m_a} + {1'b0, ~b} + 9'd1;
		m_p[0] = s[8];
	end
	8'h29: m_a = m_a & b;
	8'h09: m_a = m_a | b;
	8'h49: m_a = m_a ^ b;
	8'h0A: {m_p[0], m_a} = {m_a, 1'b0};
	8'h4A: {m_a, m_p[0]} = {1'b0, m_a};
	8'h2A: {m_p[0], m_a} = {m_a, m_p[0]};
	8'h6A: {m_a, m_p[0]} = {m_p[0], m_a};
	default: ;
	endcase
	m_p = nz(m_p, (opc == 8'hC9) ? s[7:0] : m_a);
endtask

// Append the closing loop, run the core and compare the port activity
task automatic run_prog();
	cpu_pkg::addr_t e;
	int n;
	e = pc_w;
	abs(8'h4C, e, 3);
	n = ins_addr.size();
	foreach (ins_cyc[i])
		budget = budget + ins_cyc[i];
	budget = budget + 6;
	@(posedge sys);
	rst_i <= 1'b0;
	while (sync_a.size() < n + 1)
		@(negedge sys);
	check_addr("first fetch addr_o", sync_a[0], vec);
	check_count("cycles to first fetch", sync_t[0], 3);
	for (int i = 0; i <= n; i++) begin
		check_addr("fetch addr_o", sync_a[i], (i < n) ? ins_addr[i] : e);
		if (i < n)
			check_count("cycles between sync_o", sync_t[i + 1] - sync_t[i], ins_cyc[i]);
	end
	check_count("number of writes", wr_a.size(), exp_wa.size());
	foreach (exp_wa[i]) begin
		check_addr("write addr_o", wr_a[i], exp_wa[i]);
		check_data("write data_o", wr_d[i], exp_wd[i]);
	end
endtask

task automatic test_load_store();
	cpu_pkg::data_t v [0:8];
	foreach (v[i])
		v[i] = next_byte();
	start_prog();
	mem[16'h0020] = v[3];
	mem[16'h0420] = v[4];
	mem[16'h0021] = v[5];
	mem[16'h0421] = v[6];
	mem[16'h0022] = v[7];
	mem[16'h0422] = v[8];
	imm(8'hA9, v[0]);
	zp(8'h85, 8'h40);
	imm(8'hA2, v[1]);
	abs(8'h8E, 16'h0440, 4);
	imm(8'hA0, v[2]);
	zp(8'h84, 8'h41);
	zp(8'hA5, 8'h20);
	abs(8'h8D, 16'h0441, 4);
	abs(8'hAE, 16'h0420, 4);
	zp(8'h86, 8'h42);
	zp(8'hA4, 8'h21);
	abs(8'h8C, 16'h0442, 4);
	abs(8'hAD, 16'h0421, 4);
	zp(8'h85, 8'h43);
	zp(8'hA6, 8'h22);
	abs(8'h8E, 16'h0443, 4);
	abs(8'hAC, 16'h0422, 4);
	zp(8'h84, 8'h44);
	expect_wr(16'h0040, v[0]);
	expect_wr(16'h0440, v[1]);
	expect_wr(16'h0041, v[2]);
	expect_wr(16'h0441, v[3]);
	expect_wr(16'h0042, v[4]);
	expect_wr(16'h0442, v[5]);
	expect_wr(16'h0043, v[6]);
	expect_wr(16'h0443, v[7]);
	expect_wr(16'h0044, v[8]);
	run_prog();
endtask

task automatic test_alu_flags();
	cpu_pkg::data_t ops [0:9] = '{8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
		8'hC9, 8'h0A, 8'h4A, 8'h2A, 8'h6A};
	cpu_pkg::data_t a, b;
	start_prog();
	foreach (ops[k]) begin
		a = next_byte();
		b = next_byte();
		ins(b[0] ? 8'h38 : 8'h18, 2);
		m_p[0] = b[0];
		imm(8'hA9, a);
		m_a = a;
		m_p = nz(m_p, a);
		if (ops[k][3:0] == 4'hA)
			ins(ops[k], 2);
		else
			imm(ops[k], b);
		model_op(ops[k], b);
		zp(8'h85, cpu_pkg::data_t'(8'h50 + k));
		expect_wr({8'h00, cpu_pkg::data_t'(8'h50 + k)}, m_a);
		push_p();
	end
	// Signed overflow and the flag instructions
	imm(8'hA9, 8'h50);
	m_a = 8'h50;
	ins(8'h18, 2);
	m_p[0] = 1'b0;
	imm(8'h69, 8'h50);
	model_op(8'h69, 8'h50);
	push_p();
	ins(8'hB8, 2);
	ins(8'h58, 2);
	m_p[6] = 1'b0;
	m_p[2] = 1'b0;
	push_p();
	ins(8'h78, 2);
	m_p[2] = 1'b1;
	push_p();
	run_prog();
endtask

task automatic test_stack();
	cpu_pkg::data_t v, w, pp, s, saved;
	v = next_byte();
	w = next_byte();
	pp = next_byte();
	s = next_byte();
	start_prog();
	imm(8'hA9, v);
	m_p = nz(m_p, v);
	ins(8'h48, 3);
	expect_wr(16'h01FF, v);
	m_sp = 8'hFE;
	saved = m_p | 8'h20;
	push_p();
	imm(8'hA9, w);
	ins(8'h28, 4);
	ins(8'h68, 4);
	m_p = nz(saved, v);
	m_sp = 8'hFF;
	zp(8'h85, 8'h60);
	expect_wr(16'h0060, v);
	push_p();
	ins(8'hBA, 2);
	zp(8'h86, 8'h61);
	expect_wr(16'h0061, 8'hFE);
	imm(8'hA9, pp);
	ins(8'h48, 3);
	expect_wr(16'h01FE, pp);
	ins(8'h28, 4);
	m_p = pp;
	push_p();
	imm(8'hA2, s);
	ins(8'h9A, 2);
	ins(8'hBA, 2);
	zp(8'h86, 8'h62);
	expect_wr(16'h0062, s);
	run_prog();
endtask

task automatic test_transfers();
	cpu_pkg::data_t a, x, y;
	a = next_byte();
	x = next_byte();
	y = next_byte();
	start_prog();
	imm(8'hA9, a);
	ins(8'hAA, 2);
	ins(8'hE8, 2);
	zp(8'h86, 8'h70);
	ins(8'hA8, 2);
	ins(8'h88, 2);
	zp(8'h84, 8'h71);
	imm(8'hA2, 8'hFF);
	ins(8'hE8, 2);
	zp(8'h86, 8'h72);
	imm(8'hA0, 8'h00);
	ins(8'h88, 2);
	zp(8'h84, 8'h73);
	imm(8'hA2, x);
	ins(8'h8A, 2);
	zp(8'h85, 8'h74);
	imm(8'hA0, y);
	ins(8'h98, 2);
	zp(8'h85, 8'h75);
	ins(8'hC8, 2);
	zp(8'h84, 8'h76);
	ins(8'hCA, 2);
	zp(8'h86, 8'h77);
	expect_wr(16'h0070, a + 8'd1);
	expect_wr(16'h0071, a - 8'd1);
	expect_wr(16'h0072, 8'h00);
	expect_wr(16'h0073, 8'hFF);
	expect_wr(16'h0074, x);
	expect_wr(16'h0075, y);
	expect_wr(16'h0076, y + 8'd1);
	expect_wr(16'h0077, x - 8'd1);
	run_prog();
endtask

task automatic test_jump_timing();
	cpu_pkg::addr_t t;
	cpu_pkg::data_t v;
	v = next_byte();
	start_prog();
	ins(8'hEA, 2);
	ins(8'h78, 2);
	t = pc_w + 16'd6;
	abs(8'h4C, t, 3);
	// Skipped store that must never execute
	put(8'h8D);
	put(8'h80);
	put(8'h04);
	imm(8'hA9, v);
	zp(8'h85, 8'h64);
	abs(8'h8D, 16'h0490, 4);
	expect_wr(16'h0064, v);
	expect_wr(16'h0490, v);
	run_prog();
endtask

initial begin
	errors = 0;
	elapsed = 0;
	budget = 0;
	test_load_store();
	test_alu_flags();
	test_stack();
	test_transfers();
	test_jump_timing();
	if (errors == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

`default_nettype wire

/* filelist.f */
cpu_pkg.sv
cpu_decoder.sv
cpu_sequencer.sv
cpu_alu.sv
cpu_datapath.sv
cpu_top.sv
cpu_checker.sv
tb_cpu_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cpu_top -f filelist.f -o sim_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "no pass line in sim.log"
	exit 1
fi
exit 0
